// File: verilog/mmap_pkg.sv
/* Memory map of the SoC bus: region base values on address bits 31:24
   and the region code that the decoder hands to the response mux */
package mmap_pkg;

  // Upper address byte of each mapped region
  localparam logic [7:0] SRAM_START = 8'h10;
  localparam logic [7:0] NATV_START = 8'h20;
  localparam logic [7:0] APB_START  = 8'h30;

  // Decoded region, REG_NONE for any unmapped address
  typedef enum logic [1:0] {
    REG_SRAM,
    REG_NATV,
    REG_APB,
    REG_NONE
  } region_t;

endpackage

// File: verilog/bus_pkg.sv
/* Request and response structs for the native memory bus and the APB4 link,
   shared by the decoder, the targets and the top level */
package bus_pkg;

  // Native request, valid held until ready, reads have wstrb == 0
  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } nmi_req_t;

  // Native response, ready is a one-cycle pulse
  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } nmi_rsp_t;

  // APB4 master side signals
  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] paddr;
    logic [31:0] pwdata;
    logic [3:0]  pstrb;
  } apb_req_t;

  // APB4 slave side signals
  typedef struct packed {
    logic        pready;
    logic [31:0] prdata;
  } apb_rsp_t;

endpackage

// File: verilog/bus_decode.sv
/* Address decoder of the SoC bus, splits the core request into one gated
   request per target and reports the selected region */
`timescale 1ns/1ps

module bus_decode
  import mmap_pkg::*;
  import bus_pkg::*;
(
  input  nmi_req_t req,
  output nmi_req_t sram_req,
  output nmi_req_t natv_req,
  output nmi_req_t apb_req,
  output region_t  region
);

  // Region from the upper address byte
  always_comb begin
    case (req.addr[31:24])
      SRAM_START: region = REG_SRAM;
      NATV_START: region = REG_NATV;
      APB_START:  region = REG_APB;
      default:    region = REG_NONE;
    endcase
  end

  // Address and data fan out to every target, only valid is steered
  always_comb begin
    sram_req       = req;
    sram_req.valid = req.valid && (region == REG_SRAM);
    // SRAM sees no strobes unless it is the selected target
    if (!sram_req.valid) begin
      sram_req.wstrb = '0;
    end

    natv_req       = req;
    natv_req.valid = req.valid && (region == REG_NATV);

    apb_req        = req;
    apb_req.valid  = req.valid && (region == REG_APB);
  end

endmodule

// File: verilog/sram_port.sv
/* On-chip SRAM target, word addressed with byte strobes; answers every new
   request with a registered one-cycle ready */
`timescale 1ns/1ps

module sram_port
  import bus_pkg::*;
#(
  parameter int SRAM_AW = 8
) (
  input  logic     clk,
  input  logic     rst,
  input  nmi_req_t req,
  output nmi_rsp_t rsp
);

  logic [31:0]        mem [2**SRAM_AW];
  logic [SRAM_AW-1:0] idx;
  logic               ready_q;
  logic [31:0]        rdata_q;
  logic               req_new;

  // Word index, upper address bits wrap around the depth
  assign idx = req.addr[SRAM_AW+1:2];

  // Held request is served once, skip the cycle where ready is up
  assign req_new = req.valid && !ready_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= req_new;
    end
  end

  // Storage and read port
  always_ff @(posedge clk) begin
    if (req_new) begin
      for (int b = 0; b < 4; b++) begin
        if (req.wstrb[b]) begin
          mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
        end
      end
      rdata_q <= mem[idx];
    end
  end

  assign rsp.ready = ready_q;
  assign rsp.rdata = rdata_q;

endmodule

// File: verilog/natv_regs.sv
/* Native-bus register bank of eight words with byte writes; ready is a
   registered pulse one cycle after a new request */
`timescale 1ns/1ps

module natv_regs
  import bus_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  nmi_req_t req,
  output nmi_rsp_t rsp
);

  logic [31:0] regs [8];
  logic [2:0]  sel;
  logic        ready_q;
  logic [31:0] rdata_q;
  logic        req_new;

  // Register select from word address bits
  assign sel = req.addr[4:2];

  // New only if we did not answer in this cycle
  assign req_new = req.valid && !ready_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      ready_q <= 1'b0;
      for (int i = 0; i < 8; i++) begin
        regs[i] <= '0;
      end
    end else begin
      ready_q <= req_new;
      if (req_new) begin
        // Byte-strobed write, reads leave the bank untouched
        for (int b = 0; b < 4; b++) begin
          if (req.wstrb[b]) begin
            regs[sel][8*b +: 8] <= req.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  // Read data captured with the request, shown with ready
  always_ff @(posedge clk) begin
    if (req_new) begin
      rdata_q <= regs[sel];
    end
  end

  assign rsp.ready = ready_q;
  assign rsp.rdata = rdata_q;

endmodule

// File: verilog/apb_bridge.sv
/* Native-to-APB4 bridge; runs a setup phase, then access until pready, and
   returns the slave's read data with a one-cycle ready */
`timescale 1ns/1ps

module apb_bridge
  import bus_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  nmi_req_t req,
  input  apb_rsp_t apb_rsp,
  output nmi_rsp_t rsp,
  output apb_req_t apb_req
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS
  } state_t;

  state_t state;
  state_t state_nxt;

  // Next state
  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: begin
        if (req.valid) begin
          state_nxt = ST_SETUP;
        end
      end
      ST_SETUP:  state_nxt = ST_ACCESS;
      ST_ACCESS: begin
        // Slave may insert wait states
        if (apb_rsp.pready) begin
          state_nxt = ST_IDLE;
        end
      end
      default:   state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Core holds the request, so address and data stay stable on APB
  assign apb_req.psel    = (state != ST_IDLE);
  assign apb_req.penable = (state == ST_ACCESS);
  assign apb_req.pwrite  = |req.wstrb;
  assign apb_req.paddr   = req.addr;
  assign apb_req.pwdata  = req.wdata;
  assign apb_req.pstrb   = req.wstrb;

  // Transfer completes in the access cycle that sees pready
  assign rsp.ready = (state == ST_ACCESS) && apb_rsp.pready;
  assign rsp.rdata = apb_rsp.prdata;

endmodule

// File: verilog/apb_regs.sv
/* APB4 register slave of eight words; inserts APB_WAIT wait states per
   access and applies strobed writes in the pready cycle */
`timescale 1ns/1ps

module apb_regs
  import bus_pkg::*;
#(
  parameter int APB_WAIT = 1
) (
  input  logic     clk,
  input  logic     rst,
  input  apb_req_t apb_req,
  output apb_rsp_t apb_rsp
);

  localparam int CW = (APB_WAIT > 0) ? $clog2(APB_WAIT + 1) : 1;

  logic [31:0]   regs [8];
  logic [CW-1:0] wait_cnt;
  logic          access;
  logic          done;
  logic [2:0]    sel;

  assign sel    = apb_req.paddr[4:2];
  assign access = apb_req.psel && apb_req.penable;
  // Ready once enough access cycles have gone by
  assign done   = access && (wait_cnt == CW'(APB_WAIT));

  always_ff @(posedge clk) begin
    if (rst) begin
      wait_cnt <= '0;
      for (int i = 0; i < 8; i++) begin
        regs[i] <= '0;
      end
    end else begin
      // Counter restarts for every transfer
      if (access && !done) begin
        wait_cnt <= wait_cnt + 1'b1;
      end else begin
        wait_cnt <= '0;
      end
      if (done && apb_req.pwrite) begin
        for (int b = 0; b < 4; b++) begin
          if (apb_req.pstrb[b]) begin
            regs[sel][8*b +: 8] <= apb_req.pwdata[8*b +: 8];
          end
        end
      end
    end
  end

  assign apb_rsp.pready = done;
  assign apb_rsp.prdata = regs[sel];

endmodule

// File: verilog/rsp_mux.sv
/* Response path back to the core; merges the target readies, picks read data
   by region and answers unmapped requests with zero data itself */
`timescale 1ns/1ps

module rsp_mux
  import mmap_pkg::*;
  import bus_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     req_valid,
  input  region_t  region,
  input  nmi_rsp_t sram_rsp,
  input  nmi_rsp_t natv_rsp,
  input  nmi_rsp_t apb_rsp,
  output nmi_rsp_t core_rsp
);

  logic none_ready;

  // Unmapped responder, same one-cycle timing as the memory targets
  always_ff @(posedge clk) begin
    if (rst) begin
      none_ready <= 1'b0;
    end else begin
      none_ready <= req_valid && (region == REG_NONE) && !none_ready;
    end
  end

  assign core_rsp.ready = sram_rsp.ready | natv_rsp.ready | apb_rsp.ready | none_ready;

  // Data only from the target that answers, zero otherwise
  always_comb begin
    core_rsp.rdata = '0;
    case (region)
      REG_SRAM: if (sram_rsp.ready) core_rsp.rdata = sram_rsp.rdata;
      REG_NATV: if (natv_rsp.ready) core_rsp.rdata = natv_rsp.rdata;
      REG_APB:  if (apb_rsp.ready) core_rsp.rdata = apb_rsp.rdata;
      default:  core_rsp.rdata = '0;
    endcase
  end

endmodule

// File: verilog/soc_bus_top.sv
/* SoC memory bus top level; core request in, response out, with SRAM,
   native register bank and APB slave behind one decoder */
`timescale 1ns/1ps

module soc_bus_top
  import mmap_pkg::*;
  import bus_pkg::*;
#(
  parameter int SRAM_AW  = 8,
  parameter int APB_WAIT = 1
) (
  input  logic     clk,
  input  logic     rst,
  input  nmi_req_t core_req,
  output nmi_rsp_t core_rsp
);

  nmi_req_t sram_req;
  nmi_req_t natv_req;
  nmi_req_t apb_nreq;
  nmi_rsp_t sram_rsp;
  nmi_rsp_t natv_rsp;
  nmi_rsp_t apb_nrsp;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;
  region_t  region;

  // Decode
  bus_decode u_decode (
    .req      (core_req),
    .sram_req (sram_req),
    .natv_req (natv_req),
    .apb_req  (apb_nreq),
    .region   (region)
  );

  // Targets
  sram_port #(.SRAM_AW(SRAM_AW)) u_sram (
    .clk (clk),
    .rst (rst),
    .req (sram_req),
    .rsp (sram_rsp)
  );

  natv_regs u_natv (
    .clk (clk),
    .rst (rst),
    .req (natv_req),
    .rsp (natv_rsp)
  );

  apb_bridge u_bridge (
    .clk     (clk),
    .rst     (rst),
    .req     (apb_nreq),
    .apb_rsp (apb_rsp),
    .rsp     (apb_nrsp),
    .apb_req (apb_req)
  );

  apb_regs #(.APB_WAIT(APB_WAIT)) u_apb_regs (
    .clk     (clk),
    .rst     (rst),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp)
  );

  // Result back to the core
  rsp_mux u_rsp_mux (
    .clk       (clk),
    .rst       (rst),
    .req_valid (core_req.valid),
    .region    (region),
    .sram_rsp  (sram_rsp),
    .natv_rsp  (natv_rsp),
    .apb_rsp   (apb_nrsp),
    .core_rsp  (core_rsp)
  );

endmodule

// File: bench/tb_clkgen.sv
/* Free-running testbench clock, starts low */
`timescale 1ns/1ps

module tb_clkgen #(
  parameter int PERIOD = 40
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  // Half period per phase
  always begin
    #(PERIOD / 2);
    clk = ~clk;
  end

endmodule

// File: bench/bus_props.sv
/* Concurrent checks bound into the APB bridge; core request hold and the
   APB4 setup and access rules, failures counted in fail_cnt */
`timescale 1ns/1ps

module bus_props
  import bus_pkg::*;
(
  input logic     clk,
  input logic     rst,
  input nmi_req_t req,
  input nmi_rsp_t rsp,
  input apb_req_t apb_req,
  input apb_rsp_t apb_rsp
);

  int fail_cnt = 0;

  // Address, data and direction hold from setup to the pready cycle
  apb_stable: assert property (@(posedge clk) disable iff (rst)
    apb_req.psel && !apb_rsp.pready |=> apb_req.psel && $stable(apb_req.paddr)
      && $stable(apb_req.pwdata) && $stable(apb_req.pwrite) && $stable(apb_req.pstrb))
    else begin
      fail_cnt++;
      $error("APB request changed before pready");
    end

  // Setup cycle is always followed by access
  apb_setup_access: assert property (@(posedge clk) disable iff (rst)
    apb_req.psel && !apb_req.penable |=> apb_req.psel && apb_req.penable)
    else begin
      fail_cnt++;
      $error("APB setup cycle not followed by access");
    end

  // No access phase without a setup cycle before it
  apb_access_after_setup: assert property (@(posedge clk) disable iff (rst)
    $rose(apb_req.penable) |-> $past(apb_req.psel && !apb_req.penable))
    else begin
      fail_cnt++;
      $error("APB penable rose without a setup cycle");
    end

  // Core keeps its request until the bridge answers
  core_hold: assert property (@(posedge clk) disable iff (rst)
    req.valid && !rsp.ready |=> req.valid && $stable(req.addr)
      && $stable(req.wdata) && $stable(req.wstrb))
    else begin
      fail_cnt++;
      $error("Core request dropped or changed before ready");
    end

endmodule

// Bridge sees both the core side and the APB link
bind apb_bridge bus_props u_props (
  .clk     (clk),
  .rst     (rst),
  .req     (req),
  .rsp     (rsp),
  .apb_req (apb_req),
  .apb_rsp (apb_rsp)
);

// File: bench/tb_soc_bus.sv
/* Testbench of the SoC memory bus. Random core traffic is checked against a word
   model of the SRAM and both register banks and against the fixed latencies */
`timescale 1ns/1ps

module tb_soc_bus
  import mmap_pkg::*;
  import bus_pkg::*;
();

  localparam int SRAM_AW  = 8;
  localparam int APB_WAIT = 1;
  localparam int DEPTH    = 2**SRAM_AW;

  logic     clk;
  logic     rst;
  nmi_req_t core_req;
  nmi_rsp_t core_rsp;

  // Reference model of the three targets
  logic [31:0] sram_m [DEPTH];
  logic [31:0] natv_m [8];
  logic [31:0] apb_m  [8];

  int seed = 33;
  int errors = 0;
  int prop_errors;

  tb_clkgen #(.PERIOD(40)) u_clk (
    .clk (clk)
  );

  soc_bus_top #(.SRAM_AW(SRAM_AW), .APB_WAIT(APB_WAIT)) uut (
    .clk      (clk),
    .rst      (rst),
    .core_req (core_req),
    .core_rsp (core_rsp)
  );

  function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                              input logic [31:0] wdata,
                                              input logic [3:0]  wstrb);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (wstrb[b]) begin
        res[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic bit is_mapped(input logic [31:0] addr);
    return addr[31:24] == SRAM_START || addr[31:24] == NATV_START
        || addr[31:24] == APB_START;
  endfunction

  // APB pays a setup cycle plus wait states and the rest answer in one cycle
  function automatic int exp_latency(input logic [31:0] addr);
    if (addr[31:24] == APB_START) begin
      return 2 + APB_WAIT;
    end
    return 1;
  endfunction

  // Word-aligned random address in the region picked by kind, kind 3 is unmapped
  function automatic logic [31:0] rand_addr(input int kind);
    logic [31:0] a;
    a = $random(seed);
    a[1:0] = 2'b00;
    case (kind)
      0:       a[31:24] = SRAM_START;
      1:       a[31:24] = NATV_START;
      2:       a[31:24] = APB_START;
      default: begin
        if (is_mapped(a)) begin
          a[31:24] = a[31:24] ^ 8'h01;
        end
      end
    endcase
    return a;
  endfunction

  // Returns the old word as read data and merges the write into the model
  task automatic model_access(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] wstrb, output logic [31:0] exp);
    logic [SRAM_AW-1:0] idx;
    logic [2:0]         sel;
    idx = addr[SRAM_AW+1:2];
    sel = addr[4:2];
    exp = '0;
    case (addr[31:24])
      SRAM_START: begin
        exp = sram_m[idx];
        sram_m[idx] = merge_bytes(sram_m[idx], wdata, wstrb);
      end
      NATV_START: begin
        exp = natv_m[sel];
        natv_m[sel] = merge_bytes(natv_m[sel], wdata, wstrb);
      end
      APB_START: begin
        exp = apb_m[sel];
        apb_m[sel] = merge_bytes(apb_m[sel], wdata, wstrb);
      end
      default: exp = '0;
    endcase
  endtask

  // Starts 2 ns after a rising edge and returns at the same point of a later cycle
  task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb);
    logic [31:0] exp;
    int          cycles;
    bit          got;
    model_access(addr, wdata, wstrb, exp);
    core_req.valid = 1'b1;
    core_req.addr  = addr;
    core_req.wdata = wdata;
    core_req.wstrb = wstrb;
    cycles = 0;
    got = 1'b0;
    while (!got && cycles < 50) begin
      @(posedge clk);
      #1;
      cycles++;
      got = core_rsp.ready;
    end
    if (!got) begin
      $display("No ready came for address %h within 50 cycles", addr);
      errors++;
    end else begin
      if (cycles != exp_latency(addr)) begin
        $display("ERROR latency at address %h: got %0h expected %0h",
                 addr, cycles, exp_latency(addr));
        errors++;
      end
      // Writes carry no data apart from the zero of the unmapped responder
      if ((wstrb == 4'h0 || !is_mapped(addr)) && core_rsp.rdata !== exp) begin
        $display("ERROR core_rsp.rdata at address %h: got %h expected %h",
                 addr, core_rsp.rdata, exp);
        errors++;
      end
      @(posedge clk);
      #1;
      if (core_rsp.ready) begin
        $display("ERROR core_rsp.ready at address %h: got %h expected %h",
                 addr, core_rsp.ready, 1'b0);
        errors++;
      end
    end
    #1;
    core_req = '0;
  endtask

  initial begin
    logic [31:0] a;
    logic [31:0] rnd;
    logic [3:0]  strb;
    int          gap;
    rst = 1'b1;
    core_req = '0;
    for (int i = 0; i < 8; i++) begin
      natv_m[i] = '0;
      apb_m[i] = '0;
    end
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;

    // Both banks read zero after reset
    for (int i = 0; i < 8; i++) begin
      bus_access({NATV_START, 24'h0} | (i << 2), 32'h0, 4'h0);
      bus_access({APB_START, 24'h0} | (i << 2), 32'h0, 4'h0);
    end

    // Fill every SRAM word with a value from its whole address
    for (int i = 0; i < DEPTH; i++) begin
      a = {SRAM_START, 24'h0} | (i << 2);
      bus_access(a, a ^ {a[15:0], a[31:16]}, 4'hf);
    end

    // Strobed SRAM writes read back directly and through an aliased address
    for (int i = 0; i < 60; i++) begin
      a = rand_addr(0);
      rnd = $random(seed);
      strb = rnd[3:0];
      if (strb == 4'h0) begin
        strb = 4'h1;
      end
      bus_access(a, $random(seed), strb);
      bus_access(a, 32'h0, 4'h0);
      bus_access(a ^ (32'h1 << (SRAM_AW + 2)), 32'h0, 4'h0);
    end

    // Same offset in both banks holds separate values
    for (int i = 0; i < 8; i++) begin
      bus_access({NATV_START, 24'h0} | (i << 2), $random(seed), 4'hf);
      bus_access({APB_START, 24'h0} | (i << 2), $random(seed), 4'hf);
      bus_access({NATV_START, 24'h0} | (i << 2), 32'h0, 4'h0);
      bus_access({APB_START, 24'h0} | (i << 2), 32'h0, 4'h0);
    end

    // Unmapped writes and reads followed by the same offset in every region
    for (int i = 0; i < 20; i++) begin
      a = rand_addr(3);
      bus_access(a, $random(seed), 4'hf);
      bus_access(a, 32'h0, 4'h0);
      bus_access({SRAM_START, a[23:0]}, 32'h0, 4'h0);
      bus_access({NATV_START, a[23:0]}, 32'h0, 4'h0);
      bus_access({APB_START, a[23:0]}, 32'h0, 4'h0);
    end

    // Random mix of back-to-back requests and short idle gaps
    for (int i = 0; i < 400; i++) begin
      a = rand_addr($unsigned($random(seed)) % 4);
      rnd = $random(seed);
      strb = rnd[3:0];
      if ($random(seed) & 1) begin
        strb = 4'h0;
      end
      bus_access(a, $random(seed), strb);
      gap = $unsigned($random(seed)) % 4;
      if (gap > 0) begin
        repeat (gap) @(posedge clk);
        #2;
      end
    end

    prop_errors = uut.u_bridge.u_props.fail_cnt;
    $display("Errors: %0d in checks, %0d in assertions", errors, prop_errors);
    if (errors == 0 && prop_errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: compile.f
verilog/mmap_pkg.sv
verilog/bus_pkg.sv
verilog/bus_decode.sv
verilog/sram_port.sv
verilog/natv_regs.sv
verilog/apb_bridge.sv
verilog/apb_regs.sv
verilog/rsp_mux.sv
verilog/soc_bus_top.sv
bench/tb_clkgen.sv
bench/bus_props.sv
bench/tb_soc_bus.sv
